// File: flist.f
+incdir+verification
source/riscv_csr_pkg.sv
source/csr_stage_pkg.sv
source/csr_regfile.sv
source/trap_check.sv
source/csr_commit.sv
source/csr_top.sv
verification/csr_top_tb.sv

// File: verification/csr_model.svh
`ifndef csr_model_svh
`define csr_model_svh

// Reference copy of the architectural CSR state
priv_mode_e  model_mode;
priv_mode_e  model_mpp;
logic        model_mstatus_mie;
logic        model_mpie;
logic [31:0] model_mie;
logic [31:0] model_mtvec;
logic [31:0] model_mscratch;
logic [31:0] model_mepc;
logic [31:0] model_mcause;
logic [31:0] model_mtval;
logic [63:0] model_cycles;

function automatic void reset_model();
    model_mode        = priv_m;
    model_mpp         = priv_u;
    model_mstatus_mie = 1'b0;
    model_mpie        = 1'b0;
    model_mie         = '0;
    model_mtvec       = mtvec_reset_value;
    model_mscratch    = '0;
    model_mepc        = '0;
    model_mcause      = '0;
    model_mtval       = '0;
    model_cycles      = '0;
endfunction

// irq is {external, software, timer}
function automatic logic [31:0] csr_read_value(input logic [11:0] addr, input logic [2:0] irq);
    case (addr)
        addr_mstatus:  return {19'd0, model_mpp, 3'd0, model_mpie, 3'd0, model_mstatus_mie, 3'd0};
        addr_misa:     return 32'h4000_0000 | (32'd1 << 8) | (32'd1 << 20);
        addr_mie:      return model_mie;
        addr_mtvec:    return model_mtvec;
        addr_mscratch: return model_mscratch;
        addr_mepc:     return model_mepc;
        addr_mcause:   return model_mcause;
        addr_mtval:    return model_mtval;
        addr_mip:      return {20'd0, irq[2], 3'd0, irq[0], 3'd0, irq[1], 3'd0};
        addr_mcycle:   return model_cycles[31:0];
        addr_mcycleh:  return model_cycles[63:32];
        addr_mhartid:  return hart_id_value;
        default:       return '0;
    endcase
endfunction

// Expected response of one accepted request, and the state it leaves behind
function automatic csr_rsp_t predict_response(input csr_req_t r, input logic [2:0] irq);
    csr_rsp_t    exp;
    logic [31:0] old_value;
    logic [31:0] new_value;
    logic [31:0] cause;
    logic [31:0] base;
    logic [2:0]  pending;
    logic        writes;
    logic        illegal;
    logic        exception;
    logic        take_int;
    logic        mret_done;

    old_value = csr_read_value(r.addr, irq);
    writes    = r.op inside {op_write, op_set, op_clear};
    illegal   = (writes && ((r.addr[9:8] > model_mode) || (r.addr[11:10] == 2'b11)))
                || ((r.op == op_mret) && (model_mode == priv_u));
    exception = illegal || (r.op == op_ecall);
    pending   = irq & {model_mie[11], model_mie[3], model_mie[7]};
    take_int  = !exception && ((model_mode == priv_u) || model_mstatus_mie) && (pending != 0);
    mret_done = (r.op == op_mret) && !exception && !take_int;
    base      = {model_mtvec[31:2], 2'b00};

    if (illegal) cause = 32'd2;
    else if (r.op == op_ecall) cause = (model_mode == priv_m) ? 32'd11 : 32'd8;
    else if (pending[2]) cause = 32'h8000_000B;
    else if (pending[1]) cause = 32'h8000_0003;
    else cause = 32'h8000_0007;

    exp.trap     = exception || take_int;
    exp.rdata    = exp.trap ? '0 : old_value;
    exp.redirect = exp.trap || mret_done;
    if (exception) exp.target = base;
    else if (take_int && (model_mtvec[1:0] == 2'b01))
        exp.target = base + 4 * (cause & 32'h7FFF_FFFF);
    else if (take_int) exp.target = base;
    else if (mret_done) exp.target = model_mepc;
    else exp.target = '0;

    if (exp.trap) begin
        model_mepc        = r.pc;
        model_mcause      = cause;
        model_mtval       = illegal ? r.inst : '0;
        model_mpie        = model_mstatus_mie;
        model_mstatus_mie = 1'b0;
        model_mpp         = model_mode;
        model_mode        = priv_m;
    end else if (mret_done) begin
        model_mode        = model_mpp;
        model_mstatus_mie = model_mpie;
        model_mpie        = 1'b1;
        model_mpp         = priv_u;
    end else if (writes) begin
        case (r.op)
            op_write: new_value = r.operand;
            op_set:   new_value = old_value | r.operand;
            default:  new_value = old_value & ~r.operand;
        endcase
        case (r.addr)
            addr_mstatus: begin
                model_mstatus_mie = new_value[3];
                model_mpie        = new_value[7];
                model_mpp         = (new_value[12:11] == 2'b11) ? priv_m : priv_u;
            end
            addr_mie:      model_mie      = new_value & 32'h0000_0888;
            addr_mtvec:    model_mtvec    = new_value;
            addr_mscratch: model_mscratch = new_value;
            addr_mepc:     model_mepc     = new_value & ~32'd3;
            addr_mcause:   model_mcause   = new_value;
            addr_mtval:    model_mtval    = new_value;
            default: begin
            end
        endcase
    end
    return exp;
endfunction

`endif

// File: verification/csr_top_tb.sv
module csr_top_tb;
    import riscv_csr_pkg::*;
    import csr_stage_pkg::*;

    localparam int          num_requests      = 400;
    localparam int          reset_cycles      = 3;
    localparam int          cycle_limit       = num_requests * 8;
    localparam logic [31:0] hart_id_value     = 32'h0000_0005;
    // Vectored mode right after reset
    localparam logic [31:0] mtvec_reset_value = 32'h0000_1001;

    logic     clk;
    logic     rst_n;
    csr_req_t req;
    logic     req_valid;
    logic     req_ready;
    csr_rsp_t rsp;
    logic     rsp_valid;
    logic     rsp_ready;
    logic     irq_external;
    logic     irq_software;
    logic     irq_timer;

    integer   seed;
    int       sent = 0;
    int       received = 0;
    int       checks = 0;
    int       errors = 0;
    int       cycles = 0;
    logic     stalled = 1'b0;
    logic     valid_expected = 1'b0;
    logic     ready_expected;
    csr_rsp_t held_rsp;
    csr_rsp_t expected_q[$];

    `include "csr_model.svh"

    csr_top #(
        .hart_id     (hart_id_value),
        .mtvec_reset (mtvec_reset_value)
    ) csr_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .rsp          (rsp),
        .rsp_valid    (rsp_valid),
        .rsp_ready    (rsp_ready),
        .irq_external (irq_external),
        .irq_software (irq_software),
        .irq_timer    (irq_timer)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [11:0] random_address();
        case ($unsigned($random(seed)) % 15)
            0:  return addr_mstatus;
            1:  return addr_misa;
            2:  return addr_mie;
            3:  return addr_mtvec;
            4:  return addr_mscratch;
            5:  return addr_mepc;
            6:  return addr_mcause;
            7:  return addr_mtval;
            8:  return addr_mip;
            9:  return addr_mcycle;
            10: return addr_mcycleh;
            11: return addr_mhartid;
            // Unknown M-level, S-level and read-only user addresses
            12: return 12'h7C0;
            13: return 12'h140;
            default: return 12'hC00;
        endcase
    endfunction

    function automatic csr_req_t random_request();
        csr_req_t r;
        int unsigned pick;

        pick = $unsigned($random(seed)) % 11;
        if (pick < 2) r.op = op_none;
        else if (pick < 5) r.op = op_write;
        else if (pick < 7) r.op = op_set;
        else if (pick < 9) r.op = op_clear;
        else if (pick < 10) r.op = op_ecall;
        else r.op = op_mret;
        r.addr    = random_address();
        r.operand = $random(seed);
        r.pc      = $random(seed) & ~32'd3;
        r.inst    = $random(seed);
        return r;
    endfunction

    task automatic check_response(input csr_rsp_t exp);
        checks++;
        assert (rsp.rdata === exp.rdata) else begin
            errors++;
            $display("error at %0t: rsp.rdata got %h expected %h", $time, rsp.rdata, exp.rdata);
        end
        assert (rsp.trap === exp.trap) else begin
            errors++;
            $display("error at %0t: rsp.trap got %b expected %b", $time, rsp.trap, exp.trap);
        end
        assert (rsp.redirect === exp.redirect) else begin
            errors++;
            $display("error at %0t: rsp.redirect got %b expected %b",
                     $time, rsp.redirect, exp.redirect);
        end
        assert (rsp.target === exp.target) else begin
            errors++;
            $display("error at %0t: rsp.target got %h expected %h", $time, rsp.target, exp.target);
        end
    endtask

    // Stimulus, reset and end of run
    initial begin
        seed         = 46555;
        rst_n        = 1'b0;
        req          = '0;
        req_valid    = 1'b0;
        rsp_ready    = 1'b0;
        irq_external = 1'b0;
        irq_software = 1'b0;
        irq_timer    = 1'b0;
        reset_model();
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        while (sent < num_requests) begin
            @(posedge clk);
            if (req_valid && req_ready) sent++;
            rsp_ready    <= ($unsigned($random(seed)) % 4) != 0;
            irq_external <= ($unsigned($random(seed)) % 4) == 0;
            irq_software <= ($unsigned($random(seed)) % 4) == 0;
            irq_timer    <= ($unsigned($random(seed)) % 4) == 0;
            // A pending request holds until it is taken
            if (!req_valid || req_ready) begin
                if (sent < num_requests && ($unsigned($random(seed)) % 4) != 0) begin
                    req       <= random_request();
                    req_valid <= 1'b1;
                end else begin
                    req_valid <= 1'b0;
                end
            end
        end
        rsp_ready <= 1'b1;
        wait (received == num_requests);
        repeat (2) @(posedge clk);
        $display("checks %0d, errors %0d, responses left over %0d",
                 checks, errors, expected_q.size());
        if (errors == 0 && expected_q.size() == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Compare consumed responses, then record what was accepted on this edge
    always @(posedge clk) begin
        if (rst_n) begin
            ready_expected = !valid_expected || rsp_ready;
            assert (rsp_valid === valid_expected) else begin
                errors++;
                $display("error at %0t: rsp_valid got %b expected %b",
                         $time, rsp_valid, valid_expected);
            end
            assert (req_ready === ready_expected) else begin
                errors++;
                $display("error at %0t: req_ready got %b expected %b",
                         $time, req_ready, ready_expected);
            end
        end
        if (rsp_valid && rsp_ready) begin
            if (expected_q.size() == 0) begin
                errors++;
                $display("a response was consumed at %0t with no request outstanding", $time);
            end else begin
                check_response(expected_q.pop_front());
                received++;
            end
        end
        if (stalled) begin
            assert (rsp === held_rsp) else begin
                errors++;
                $display("error at %0t: rsp got %h expected %h", $time, rsp, held_rsp);
            end
        end
        stalled  = rsp_valid && !rsp_ready;
        held_rsp = rsp;
        // Slot fills on acceptance and empties once consumed
        valid_expected = rst_n && ((req_valid && req_ready) || (valid_expected && !rsp_ready));
        if (req_valid && req_ready) begin
            expected_q.push_back(predict_response(req, {irq_external, irq_software, irq_timer}));
        end
        if (rst_n) begin
            model_cycles = model_cycles + 64'd1;
        end else begin
            reset_model();
        end
    end

    initial begin
        wait (rst_n === 1'b1);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: %0d of %0d responses after %0d cycles", received, num_requests, cycles);
        $display("sim failed");
        $finish;
    end

endmodule

// File: source/csr_top.sv
module csr_top #(
    parameter logic [riscv_csr_pkg::xlen-1:0] hart_id     = '0,
    parameter logic [riscv_csr_pkg::xlen-1:0] mtvec_reset = '0
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  csr_stage_pkg::csr_req_t  req,
    input  logic                     req_valid,
    output logic                     req_ready,
    output csr_stage_pkg::csr_rsp_t  rsp,
    output logic                     rsp_valid,
    input  logic                     rsp_ready,
    input  logic                     irq_external,
    input  logic                     irq_software,
    input  logic                     irq_timer
);
    import riscv_csr_pkg::*;
    import csr_stage_pkg::*;

    logic [xlen-1:0] rdata;
    csr_state_t      state;
    trap_info_t      trap;
    csr_update_t     update;

    csr_regfile #(
        .hart_id     (hart_id),
        .mtvec_reset (mtvec_reset)
    ) csr_regfile_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .update       (update),
        .irq_external (irq_external),
        .irq_software (irq_software),
        .irq_timer    (irq_timer),
        .rdata        (rdata),
        .state        (state)
    );

    trap_check trap_check_i (
        .req   (req),
        .state (state),
        .trap  (trap)
    );

    csr_commit csr_commit_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_valid (req_valid),
        .rsp_ready (rsp_ready),
        .rdata     (rdata),
        .trap      (trap),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .update    (update)
    );

endmodule

// File: source/csr_commit.sv
module csr_commit (
    input  logic                           clk,
    input  logic                           rst_n,
    input  csr_stage_pkg::csr_req_t        req,
    input  logic                           req_valid,
    input  logic                           rsp_ready,
    input  logic [riscv_csr_pkg::xlen-1:0] rdata,
    input  csr_stage_pkg::trap_info_t      trap,
    output logic                           req_ready,
    output csr_stage_pkg::csr_rsp_t        rsp,
    output logic                           rsp_valid,
    output csr_stage_pkg::csr_update_t     update
);
    import riscv_csr_pkg::*;
    import csr_stage_pkg::*;

    logic     accept;
    csr_rsp_t rsp_next;

    // Stage is free when its output slot is empty or draining this cycle
    assign req_ready = !rsp_valid || rsp_ready;
    assign accept    = req_valid && req_ready;

    always_comb begin
        update.fire     = accept;
        update.write_en = op_writes(req.op) && !trap.take_trap;
        update.trap     = trap;
    end

    // Response built from the pre-write read and the trap decision
    always_comb begin
        rsp_next.rdata    = trap.take_trap ? '0 : rdata;
        rsp_next.trap     = trap.take_trap;
        rsp_next.redirect = trap.take_trap || trap.is_mret;
        rsp_next.target   = trap.target;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else if (accept) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rsp <= rsp_next;
        end
    end

    // Stalled response stays put until the consumer takes it
    rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule

// File: source/trap_check.sv
module trap_check (
    input  csr_stage_pkg::csr_req_t   req,
    input  csr_stage_pkg::csr_state_t state,
    output csr_stage_pkg::trap_info_t trap
);
    import riscv_csr_pkg::*;

    logic            illegal_write;
    logic            illegal_mret;
    logic            illegal;
    logic            is_ecall;
    logic            exception;
    logic            intr_enabled;
    logic [2:0]      pend_en;
    logic            take_intr;
    logic [xlen-1:0] exc_cause;
    logic [xlen-1:0] intr_cause;
    logic [xlen-1:0] base;

    // Privilege level in addr[9:8], read-only space at addr[11:10] == 11
    assign illegal_write = op_writes(req.op) &&
                           ((req.addr[9:8] > state.mode) || (req.addr[11:10] == 2'b11));
    assign illegal_mret  = (req.op == op_mret) && (state.mode == priv_u);
    assign illegal       = illegal_write || illegal_mret;
    assign is_ecall      = (req.op == op_ecall);
    assign exception     = illegal || is_ecall;

    // U mode is always interruptible by M-level interrupts
    assign intr_enabled = (state.mode == priv_u) || state.mstatus_mie;
    assign pend_en = {state.mip_meip && state.mie_meie,
                      state.mip_msip && state.mie_msie,
                      state.mip_mtip && state.mie_mtie};
    assign take_intr = !exception && intr_enabled && (pend_en != 3'b000);

    always_comb begin
        if (illegal) begin
            exc_cause = cause_illegal_inst;
        end else if (state.mode == priv_m) begin
            exc_cause = cause_ecall_m;
        end else begin
            exc_cause = cause_ecall_u;
        end
    end

    // Fixed priority MEI, MSI, MTI
    always_comb begin
        if (pend_en[2]) begin
            intr_cause = cause_mei;
        end else if (pend_en[1]) begin
            intr_cause = cause_msi;
        end else begin
            intr_cause = cause_mti;
        end
    end

    assign base = {state.mtvec[xlen-1:2], 2'b00};

    always_comb begin
        trap.take_trap    = exception || take_intr;
        trap.is_interrupt = take_intr;
        // Pending interrupt preempts the MRET itself
        trap.is_mret      = (req.op == op_mret) && !illegal_mret && !take_intr;
        trap.cause        = exception ? exc_cause : intr_cause;
        trap.tval         = illegal ? req.inst : '0;
        if (exception) begin
            trap.target = base;
        end else if (take_intr) begin
            if (state.mtvec[1:0] == mtvec_mode_vectored) begin
                trap.target = base + {intr_cause[xlen-3:0], 2'b00};
            end else begin
                trap.target = base;
            end
        end else if (trap.is_mret) begin
            trap.target = state.mepc;
        end else begin
            trap.target = '0;
        end
    end

    // Interrupts are only ever taken as traps
    always_comb begin
        decision_consistent: assert final (!trap.is_interrupt || trap.take_trap);
    end

endmodule

// File: source/csr_regfile.sv
module csr_regfile #(
    parameter logic [riscv_csr_pkg::xlen-1:0] hart_id     = '0,
    parameter logic [riscv_csr_pkg::xlen-1:0] mtvec_reset = '0
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  csr_stage_pkg::csr_req_t           req,
    input  csr_stage_pkg::csr_update_t        update,
    input  logic                              irq_external,
    input  logic                              irq_software,
    input  logic                              irq_timer,
    output logic [riscv_csr_pkg::xlen-1:0]    rdata,
    output csr_stage_pkg::csr_state_t         state
);
    import riscv_csr_pkg::*;

    priv_mode_e      mode;
    priv_mode_e      status_mpp;
    logic            status_mie;
    logic            status_mpie;
    logic            mie_meie;
    logic            mie_msie;
    logic            mie_mtie;
    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mscratch;
    logic [xlen-1:0] mepc;
    logic [xlen-1:0] mcause;
    logic [xlen-1:0] mtval;
    logic [63:0]     mcycle;

    logic [xlen-1:0] mstatus_value;
    logic [xlen-1:0] mie_value;
    logic [xlen-1:0] mip_value;
    logic [xlen-1:0] wdata;

    // Architectural views of the packed fields
    always_comb begin
        mstatus_value = '0;
        mstatus_value[mstatus_mie_bit] = status_mie;
        mstatus_value[mstatus_mpie_bit] = status_mpie;
        mstatus_value[mpp_lsb +: 2] = status_mpp;

        mie_value = '0;
        mie_value[irq_msi_bit] = mie_msie;
        mie_value[irq_mti_bit] = mie_mtie;
        mie_value[irq_mei_bit] = mie_meie;

        // mip follows the interrupt lines directly
        mip_value = '0;
        mip_value[irq_msi_bit] = irq_software;
        mip_value[irq_mti_bit] = irq_timer;
        mip_value[irq_mei_bit] = irq_external;
    end

    always_comb begin
        case (req.addr)
            addr_mstatus:  rdata = mstatus_value;
            addr_misa:     rdata = misa_value;
            addr_mie:      rdata = mie_value;
            addr_mtvec:    rdata = mtvec;
            addr_mscratch: rdata = mscratch;
            addr_mepc:     rdata = mepc;
            addr_mcause:   rdata = mcause;
            addr_mtval:    rdata = mtval;
            addr_mip:      rdata = mip_value;
            addr_mcycle:   rdata = mcycle[31:0];
            addr_mcycleh:  rdata = mcycle[63:32];
            addr_mhartid:  rdata = hart_id;
            default:       rdata = '0;
        endcase
    end

    // Merge of the operand with the old value
    always_comb begin
        case (req.op)
            op_write: wdata = req.operand;
            op_set:   wdata = rdata | req.operand;
            op_clear: wdata = rdata & ~req.operand;
            default:  wdata = rdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mode        <= priv_m;
            status_mpp  <= priv_u;
            status_mie  <= 1'b0;
            status_mpie <= 1'b0;
            mie_meie    <= 1'b0;
            mie_msie    <= 1'b0;
            mie_mtie    <= 1'b0;
            mtvec       <= mtvec_reset;
            mscratch    <= '0;
            mepc        <= '0;
            mcause      <= '0;
            mtval       <= '0;
            mcycle      <= '0;
        end else begin
            mcycle <= mcycle + 64'd1;
            if (update.fire && update.trap.take_trap) begin
                mepc        <= req.pc;
                mcause      <= update.trap.cause;
                mtval       <= update.trap.tval;
                status_mpie <= status_mie;
                status_mie  <= 1'b0;
                status_mpp  <= mode;
                mode        <= priv_m;
            end else if (update.fire && update.trap.is_mret) begin
                mode        <= status_mpp;
                status_mie  <= status_mpie;
                status_mpie <= 1'b1;
                status_mpp  <= priv_u;
            end else if (update.fire && update.write_en) begin
                case (req.addr)
                    addr_mstatus: begin
                        status_mie  <= wdata[mstatus_mie_bit];
                        status_mpie <= wdata[mstatus_mpie_bit];
                        // Anything but M falls back to U
                        status_mpp  <= (wdata[mpp_lsb +: 2] == 2'b11) ? priv_m : priv_u;
                    end
                    addr_mie: begin
                        mie_msie <= wdata[irq_msi_bit];
                        mie_mtie <= wdata[irq_mti_bit];
                        mie_meie <= wdata[irq_mei_bit];
                    end
                    addr_mtvec:    mtvec    <= wdata;
                    addr_mscratch: mscratch <= wdata;
                    addr_mepc:     mepc     <= {wdata[xlen-1:2], 2'b00};
                    addr_mcause:   mcause   <= wdata;
                    addr_mtval:    mtval    <= wdata;
                    default: begin
                    end
                endcase
            end
        end
    end

    always_comb begin
        state.mode         = mode;
        state.mstatus_mie  = status_mie;
        state.mstatus_mpie = status_mpie;
        state.mie_meie     = mie_meie;
        state.mie_msie     = mie_msie;
        state.mie_mtie     = mie_mtie;
        state.mip_meip     = irq_external;
        state.mip_msip     = irq_software;
        state.mip_mtip     = irq_timer;
        state.mtvec        = mtvec;
        state.mepc         = mepc;
    end

    // No mode other than M or U ever appears
    mode_legal: assert property (@(posedge clk) disable iff (!rst_n)
        (mode == priv_m) || (mode == priv_u));

endmodule

// File: source/csr_stage_pkg.sv
package csr_stage_pkg;

    // One instruction as handed to the stage
    typedef struct packed {
        riscv_csr_pkg::csr_op_e op;
        logic [11:0]            addr;
        logic [31:0]            operand;
        logic [31:0]            pc;
        logic [31:0]            inst;
    } csr_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        // No write-back when set
        logic        trap;
        // Fetch continues at target
        logic        redirect;
        logic [31:0] target;
    } csr_rsp_t;

    // Regfile state needed for the trap decision
    typedef struct packed {
        riscv_csr_pkg::priv_mode_e mode;
        logic                      mstatus_mie;
        logic                      mstatus_mpie;
        logic                      mie_meie;
        logic                      mie_msie;
        logic                      mie_mtie;
        logic                      mip_meip;
        logic                      mip_msip;
        logic                      mip_mtip;
        logic [31:0]               mtvec;
        logic [31:0]               mepc;
    } csr_state_t;

    typedef struct packed {
        logic        take_trap;
        logic        is_interrupt;
        logic        is_mret;
        logic [31:0] cause;
        logic [31:0] tval;
        logic [31:0] target;
    } trap_info_t;

    // Commit order back to the regfile
    typedef struct packed {
        logic       fire;
        logic       write_en;
        trap_info_t trap;
    } csr_update_t;

endpackage

// File: source/riscv_csr_pkg.sv
package riscv_csr_pkg;

    localparam int xlen = 32;

    // Only machine and user mode exist
    typedef enum logic [1:0] {
        priv_u = 2'b00,
        priv_m = 2'b11
    } priv_mode_e;

    typedef enum logic [2:0] {
        op_none,
        op_write,
        op_set,
        op_clear,
        op_ecall,
        op_mret
    } csr_op_e;

    // Machine CSR addresses
    localparam logic [11:0] addr_mstatus  = 12'h300;
    localparam logic [11:0] addr_misa     = 12'h301;
    localparam logic [11:0] addr_mie      = 12'h304;
    localparam logic [11:0] addr_mtvec    = 12'h305;
    localparam logic [11:0] addr_mscratch = 12'h340;
    localparam logic [11:0] addr_mepc     = 12'h341;
    localparam logic [11:0] addr_mcause   = 12'h342;
    localparam logic [11:0] addr_mtval    = 12'h343;
    localparam logic [11:0] addr_mip      = 12'h344;
    localparam logic [11:0] addr_mcycle   = 12'hB00;
    localparam logic [11:0] addr_mcycleh  = 12'hB80;
    localparam logic [11:0] addr_mhartid  = 12'hF14;

    // Exception and interrupt causes, bit 31 marks an interrupt
    localparam logic [31:0] cause_illegal_inst = 32'd2;
    localparam logic [31:0] cause_ecall_u      = 32'd8;
    localparam logic [31:0] cause_ecall_m      = 32'd11;
    localparam logic [31:0] cause_msi          = 32'h8000_0003;
    localparam logic [31:0] cause_mti          = 32'h8000_0007;
    localparam logic [31:0] cause_mei          = 32'h8000_000B;

    localparam int mstatus_mie_bit  = 3;
    localparam int mstatus_mpie_bit = 7;
    localparam int mpp_lsb          = 11;
    localparam int irq_msi_bit      = 3;
    localparam int irq_mti_bit      = 7;
    localparam int irq_mei_bit      = 11;

    // mtvec[1:0] encoding for vectored interrupts
    localparam logic [1:0] mtvec_mode_vectored = 2'b01;

    // MXL = 1 (32 bit), extensions I and U
    localparam logic [31:0] misa_value = 32'h4010_0100;

    function automatic logic op_writes(csr_op_e op);
        return (op == op_write) || (op == op_set) || (op == op_clear);
    endfunction

endpackage
